//--- filelist.f
verilog/pcxt_cfg_pkg.sv
verilog/pcxt_timing_pkg.sv
verilog/pcxt_apb_regs.sv
verilog/pcxt_reset_seq.sv
verilog/pcxt_clock_enables.sv
verilog/pcxt_splash_timer.sv
verilog/pcxt_board_io.sv
verilog/pcxt_sys_ctrl.sv
verif/pcxt_sys_ctrl_tb.sv

//--- verif/pcxt_sys_ctrl_tb.sv
/*
 * Self-checking testbench for the PC/XT system-control top level.
 * Drives APB, board inputs and SPI lines, checks reset timing, strobes and decodes.
 */
`timescale 1ns/1ns

module pcxt_sys_ctrl_tb;
	import pcxt_cfg_pkg::*;
	import pcxt_timing_pkg::*;

	localparam int POWERON_HOLD  = 20;
	localparam int SPLASH_SECOND = 30;
	localparam int LED_HOLD      = 10;
	localparam int ROWS          = 32;
	localparam int AUDIO_CYCLES  = 100_000;
	// Probe selectors for the level wait
	localparam int SIG_SYS = 0;
	localparam int SIG_CPU = 1;
	localparam int SIG_LED = 2;

	logic        CLK_50M;
	logic        reset_wire;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_addr_t   paddr;
	apb_data_t   pwdata;
	apb_data_t   prdata;
	logic        user_button;
	logic        sys_reset;
	logic        cpu_reset;
	logic        opl_clk;
	logic        cen_audio;
	logic        cen_opl;
	logic        dip_bank_sel;
	dip_nibble_t dip_nibble;
	video_ar_t   video_arx;
	video_ar_t   video_ary;
	logic        spi_cs;
	logic        spi_sck;
	logic        spi_mosi;
	logic        spi_miso;
	logic        sd_miso;
	logic        vsd_miso;
	logic        sd_cs;
	logic        sd_sck;
	logic        sd_mosi;
	logic        vsd_cs;
	logic        disk_activity;
	logic        led_user;

	int cycle;
	int errors;
	int rises;
	int pulses;
	int last_rise;

	// Stimulus {mda, bank, aspect[1:0], mount} and SPI {cs, sck, mosi, sd_miso, vsd_miso}
	logic [4:0]  stim_cfg [ROWS];
	logic [4:0]  stim_spi [ROWS];
	logic [3:0]  exp_nib [ROWS];
	video_ar_t   exp_arx [ROWS];
	video_ar_t   exp_ary [ROWS];
	// Expected {sd_cs, sd_sck, sd_mosi, vsd_cs, spi_miso}
	logic [4:0]  exp_spi [ROWS];

	pcxt_sys_ctrl #(
		.POWERON_HOLD_CYCLES(POWERON_HOLD),
		.SPLASH_SECOND_CYCLES(SPLASH_SECOND),
		.LED_HOLD_CYCLES(LED_HOLD)
	) DUT (.*);

	always #10 CLK_50M = ~CLK_50M;

	// Free-running cycle count used as timestamps
	always @(posedge CLK_50M) begin
		cycle <= cycle + 1;
	end

	task automatic log_error(input string msg);
		$display("ERR @%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic abort_run(input string why);
		$display("Run aborted: %s", why);
		$display("Errors: %0d", errors + 1);
		$display("Simulation failed");
		$finish;
	endtask

	////////////////////
	// APB host with two-phase transfers
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		@(negedge CLK_50M);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge CLK_50M);
		penable = 1'b1;
		@(negedge CLK_50M);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
		@(negedge CLK_50M);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge CLK_50M);
		penable = 1'b1;
		// Sample mid low phase where prdata has settled
		#5 data = prdata;
		@(negedge CLK_50M);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			SIG_SYS: return sys_reset;
			SIG_CPU: return cpu_reset;
			default: return led_user;
		endcase
	endfunction

	// Polls on falling edges and returns the cycle where the level showed up
	task automatic wait_level(input int sel, input logic level, input int limit,
			input string what, output int at);
		int   n;
		logic found;
		found = 1'b0;
		at    = 0;
		for (n = 0; n < limit && !found; n++) begin
			@(negedge CLK_50M);
			if (probe(sel) === level) begin
				found = 1'b1;
				at    = cycle;
			end
		end
		if (!found) abort_run({"timed out waiting for ", what});
	endtask

	task automatic pulse_reset(output int released);
		@(negedge CLK_50M);
		reset_wire = 1'b1;
		repeat (2) @(negedge CLK_50M);
		reset_wire = 1'b0;
		released   = cycle;
	endtask

	// One FM-clock step that checks cen_opl lands three cycles after the rise
	task automatic step_opl(input logic level);
		@(negedge CLK_50M);
		if (cen_opl === 1'b1) begin
			pulses++;
			if (cycle - last_rise != 3)
				log_error($sformatf("cen_opl %0d cycles after rise", cycle - last_rise));
		end
		if (level && !opl_clk) begin
			rises++;
			last_rise = cycle;
		end
		opl_clk = level;
	endtask

	// Expected decodes straight from the board rules
	task automatic build_table();
		int         i;
		logic [7:0] sw;
		logic [4:0] s;
		for (i = 0; i < ROWS; i++) begin
			stim_cfg[i] = i[4:0];
			stim_spi[i] = 5'($urandom);
			s  = stim_spi[i];
			sw = stim_cfg[i][4] ? 8'h3D : 8'h2D;
			exp_nib[i] = stim_cfg[i][3] ? sw[7:4] : sw[3:0];
			exp_arx[i] = (stim_cfg[i][2:1] == 2'd0) ? 13'd4 : 13'(stim_cfg[i][2:1]) - 13'd1;
			exp_ary[i] = (stim_cfg[i][2:1] == 2'd0) ? 13'd3 : 13'd0;
			// Mounted image owns the bus and the card is parked
			if (stim_cfg[i][0])
				exp_spi[i] = {1'b1, 1'b0, 1'b0, s[4], s[0]};
			else
				exp_spi[i] = {s[4], s[3], s[2], 1'b1, s[1]};
		end
	endtask

	initial begin
		apb_data_t rd;
		apb_data_t wr;
		apb_data_t last_status;
		int        rel;
		int        t_sys;
		int        t_cpu;
		int        t_on;
		int        t_off;
		int        t_hi;
		int        t_lo;
		int        wr_cyc;
		int        polls;
		int        i;
		int        count;
		logic      prev;
		longint    exp_audio;

		CLK_50M = 1'b0;
		reset_wire = 1'b1;
		{psel, penable, pwrite, paddr, pwdata} = '0;
		{user_button, opl_clk, dip_bank_sel, disk_activity} = '0;
		{spi_cs, spi_sck, spi_mosi, sd_miso, vsd_miso} = '0;
		cycle = 0;
		errors = 0;
		rises = 0;
		pulses = 0;
		last_rise = 0;
		rd = $urandom(32'h49ca_3189);
		build_table();

		////////////////////
		// Splash then power-on hold then CPU release
		pulse_reset(rel);
		if (led_user !== 1'b0 || cen_opl !== 1'b0 || cen_audio !== 1'b0)
			log_error("outputs not idle after reset");
		apb_read(REG_STATUS, rd);
		if (rd !== 32'h0) log_error($sformatf("status after reset %h", rd));
		apb_read(REG_IMAGE, rd);
		if (rd !== 32'h0) log_error($sformatf("image flag after reset %h", rd));
		apb_read(REG_LIVE, rd);
		t_lo  = cycle - 1;
		t_hi  = rel;
		polls = 0;
		while (rd[2] === 1'b1 && polls < 100) begin
			if (rd !== 32'h7) log_error($sformatf("live during splash %h", rd));
			t_hi = t_lo;
			apb_read(REG_LIVE, rd);
			t_lo = cycle - 1;
			polls++;
		end
		if (rd[2] !== 1'b0) abort_run("splash_active never cleared in the live register");
		if (rd !== 32'h3) log_error($sformatf("live after splash %h", rd));
		// Splash edge lies between the last busy sample and the first idle one
		if (t_hi >= rel + SPLASH_SECONDS * SPLASH_SECOND ||
				t_lo < rel + SPLASH_SECONDS * SPLASH_SECOND)
			log_error($sformatf("splash cleared between cycles %0d and %0d",
				t_hi - rel, t_lo - rel));
		wait_level(SIG_SYS, 1'b0, 60, "sys_reset release after splash", t_sys);
		wait_level(SIG_CPU, 1'b0, 80, "cpu_reset release after splash", t_cpu);
		// First quiet edge is one cycle after the source falls
		if (t_sys - rel != SPLASH_SECONDS * SPLASH_SECOND + POWERON_HOLD + 1)
			log_error($sformatf("sys_reset fell %0d cycles after reset", t_sys - rel));
		if (t_cpu - t_sys != CPU_RESET_DELAY)
			log_error($sformatf("cpu_reset fell %0d after sys_reset", t_cpu - t_sys));

		////////////////////
		// Splash skip followed by soft reset
		pulse_reset(rel);
		apb_write(REG_STATUS, 32'h80);
		wr_cyc = cycle;
		apb_read(REG_LIVE, rd);
		if (rd[2] !== 1'b0) log_error("splash still active after skip");
		wait_level(SIG_SYS, 1'b0, 60, "sys_reset release after skip", t_sys);
		wait_level(SIG_CPU, 1'b0, 80, "cpu_reset release after skip", t_cpu);
		if (t_sys - wr_cyc != POWERON_HOLD + 2)
			log_error($sformatf("sys_reset fell %0d after skip write", t_sys - wr_cyc));
		if (t_cpu - t_sys != CPU_RESET_DELAY)
			log_error($sformatf("cpu_reset fell %0d after sys_reset", t_cpu - t_sys));
		wr = $urandom | 32'h81;
		apb_write(REG_STATUS, wr);
		wr_cyc = cycle;
		wait_level(SIG_SYS, 1'b1, 5, "sys_reset on soft reset", t_on);
		if (cpu_reset !== 1'b1) log_error("cpu_reset not raised by soft reset");
		wait_level(SIG_SYS, 1'b0, 60, "sys_reset release after soft reset", t_sys);
		wait_level(SIG_CPU, 1'b0, 80, "cpu_reset release after soft reset", t_cpu);
		if (t_sys - wr_cyc != POWERON_HOLD + 2)
			log_error($sformatf("sys_reset fell %0d after soft reset", t_sys - wr_cyc));
		if (t_cpu - t_sys != CPU_RESET_DELAY)
			log_error($sformatf("cpu_reset fell %0d after sys_reset", t_cpu - t_sys));
		apb_read(REG_STATUS, rd);
		if (rd !== (wr & ~32'h1)) log_error($sformatf("status read %h wrote %h", rd, wr));

		////////////////////
		// Board decode table
		for (i = 0; i < ROWS; i++) begin
			wr = stim_cfg[i][0] ? (32'h1 << ($urandom % 32)) : 32'h0;
			apb_write(REG_IMAGE, wr);
			apb_read(REG_IMAGE, rd);
			if (rd !== {31'b0, stim_cfg[i][0]})
				log_error($sformatf("row %0d image %h", i, rd));
			last_status = 32'h80 | (32'(stim_cfg[i][2:1]) << 8) | (32'(stim_cfg[i][4]) << 4);
			apb_write(REG_STATUS, last_status);
			@(negedge CLK_50M);
			dip_bank_sel = stim_cfg[i][3];
			{spi_cs, spi_sck, spi_mosi, sd_miso, vsd_miso} = stim_spi[i];
			#5;
			if (dip_nibble !== exp_nib[i])
				log_error($sformatf("row %0d dip_nibble %h exp %h", i, dip_nibble, exp_nib[i]));
			if (video_arx !== exp_arx[i] || video_ary !== exp_ary[i])
				log_error($sformatf("row %0d aspect %0d:%0d", i, video_arx, video_ary));
			if ({sd_cs, sd_sck, sd_mosi, vsd_cs, spi_miso} !== exp_spi[i])
				log_error($sformatf("row %0d spi %b exp %b", i,
					{sd_cs, sd_sck, sd_mosi, vsd_cs, spi_miso}, exp_spi[i]));
		end

		////////////////////
		// Audio strobe rate and spacing
		count = 0;
		prev  = 1'b0;
		exp_audio = longint'(AUDIO_CYCLES) * AUDIO_RATE_HZ / SYS_CLK_HZ;
		repeat (AUDIO_CYCLES) begin
			@(negedge CLK_50M);
			if (cen_audio === 1'b1) count++;
			if (prev && cen_audio === 1'b1) log_error("cen_audio on adjacent cycles");
			prev = cen_audio;
		end
		if (count < exp_audio - 1 || count > exp_audio + 1)
			log_error($sformatf("cen_audio count %0d exp %0d", count, exp_audio));

		////////////////////
		// FM clock enable, disk LED and unmapped address
		repeat (20) begin
			repeat (3 + $urandom % 6) step_opl(1'b0);
			repeat (3 + $urandom % 6) step_opl(1'b1);
		end
		repeat (6) step_opl(1'b0);
		if (pulses != rises)
			log_error($sformatf("cen_opl %0d pulses for %0d rises", pulses, rises));
		@(negedge CLK_50M);
		disk_activity = 1'b1;
		wait_level(SIG_LED, 1'b1, 1, "led_user to light", t_on);
		disk_activity = 1'b0;
		wait_level(SIG_LED, 1'b0, LED_HOLD + 5, "led_user to go dark", t_off);
		if (t_off - t_on != LED_HOLD)
			log_error($sformatf("led_user lit %0d cycles", t_off - t_on));
		apb_write(4'hC, $urandom);
		apb_read(4'hC, rd);
		if (rd !== 32'h0) log_error($sformatf("unmapped read %h", rd));
		apb_read(REG_STATUS, rd);
		if (rd !== last_status) log_error("unmapped write changed the status word");

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- verilog/pcxt_sys_ctrl.sv
/*
 * Top of the PC/XT system-control glue, all in the 50 MHz domain.
 * Wires the APB registers, reset chain, clock enables and board decodes.
 */
`timescale 1ns/1ns

module pcxt_sys_ctrl #(
	parameter int POWERON_HOLD_CYCLES  = pcxt_timing_pkg::POWERON_HOLD_DEFAULT,
	parameter int SPLASH_SECOND_CYCLES = pcxt_timing_pkg::SPLASH_SECOND_DEFAULT,
	parameter int LED_HOLD_CYCLES      = pcxt_timing_pkg::LED_HOLD_DEFAULT
) (
	input  logic                      CLK_50M,
	input  logic                      reset_wire,
	// APB host port
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  pcxt_cfg_pkg::apb_addr_t   paddr,
	input  pcxt_cfg_pkg::apb_data_t   pwdata,
	output pcxt_cfg_pkg::apb_data_t   prdata,
	// Reset chain
	input  logic                      user_button,
	output logic                      sys_reset,
	output logic                      cpu_reset,
	// Clock enables
	input  logic                      opl_clk,
	output logic                      cen_audio,
	output logic                      cen_opl,
	// Board decodes
	input  logic                      dip_bank_sel,
	output pcxt_cfg_pkg::dip_nibble_t dip_nibble,
	output pcxt_cfg_pkg::video_ar_t   video_arx,
	output pcxt_cfg_pkg::video_ar_t   video_ary,
	// SD SPI, core side and card side
	input  logic                      spi_cs,
	input  logic                      spi_sck,
	input  logic                      spi_mosi,
	output logic                      spi_miso,
	input  logic                      sd_miso,
	input  logic                      vsd_miso,
	output logic                      sd_cs,
	output logic                      sd_sck,
	output logic                      sd_mosi,
	output logic                      vsd_cs,
	input  logic                      disk_activity,
	output logic                      led_user
);
	import pcxt_cfg_pkg::*;

	// Config fields and splash state
	logic        soft_reset;
	logic        mda_mode;
	logic        splash_skip;
	logic        vsd_mounted;
	logic        splash_active;
	aspect_sel_t aspect_sel;

	pcxt_apb_regs u_apb_regs (.*);

	pcxt_reset_seq #(.POWERON_HOLD_CYCLES(POWERON_HOLD_CYCLES)) u_reset_seq (.*);

	pcxt_splash_timer #(.SPLASH_SECOND_CYCLES(SPLASH_SECOND_CYCLES)) u_splash_timer (.*);

	pcxt_clock_enables u_clock_enables (.*);

	pcxt_board_io #(.LED_HOLD_CYCLES(LED_HOLD_CYCLES)) u_board_io (.*);

endmodule

//--- verilog/pcxt_board_io.sv
/*
 * Board-level decodes of the system-control block.
 * DIP nibble for port C, aspect ratio, SD SPI routing and the disk LED.
 */
`timescale 1ns/1ns

module pcxt_board_io #(
	parameter int LED_HOLD_CYCLES = pcxt_timing_pkg::LED_HOLD_DEFAULT
) (
	input  logic                      CLK_50M,
	input  logic                      reset_wire,
	input  logic                      mda_mode,
	input  logic                      dip_bank_sel,
	output pcxt_cfg_pkg::dip_nibble_t dip_nibble,
	input  pcxt_cfg_pkg::aspect_sel_t aspect_sel,
	output pcxt_cfg_pkg::video_ar_t   video_arx,
	output pcxt_cfg_pkg::video_ar_t   video_ary,
	input  logic                      vsd_mounted,
	input  logic                      spi_cs,
	input  logic                      spi_sck,
	input  logic                      spi_mosi,
	input  logic                      sd_miso,
	input  logic                      vsd_miso,
	output logic                      sd_cs,
	output logic                      sd_sck,
	output logic                      sd_mosi,
	output logic                      vsd_cs,
	output logic                      spi_miso,
	input  logic                      disk_activity,
	output logic                      led_user
);
	import pcxt_cfg_pkg::*;
	import pcxt_timing_pkg::*;

	localparam hold_count_t LED_LOAD = hold_count_t'(LED_HOLD_CYCLES);

	dip_switch_t dip_sw;
	hold_count_t led_cnt;

	////////////////////
	// DIP switches
	assign dip_sw = mda_mode ? DIP_SW_MDA : DIP_SW_CGA;
	// Port B bit 3 picks the bank on a real XT
	assign dip_nibble = dip_bank_sel ? dip_sw[7:4] : dip_sw[3:0];

	// Original 4:3, otherwise scaler presets n-1
	assign video_arx = (aspect_sel == '0) ? video_ar_t'(4)
	                                      : video_ar_t'(aspect_sel) - video_ar_t'(1);
	assign video_ary = (aspect_sel == '0) ? video_ar_t'(3) : video_ar_t'(0);

	////////////////////
	// SD SPI routing
	// Mounted image takes the bus, physical card parked deselected
	assign sd_cs    = spi_cs | vsd_mounted;
	assign sd_sck   = spi_sck & ~vsd_mounted;
	assign sd_mosi  = spi_mosi & ~vsd_mounted;
	assign vsd_cs   = spi_cs | ~vsd_mounted;
	assign spi_miso = vsd_mounted ? vsd_miso : sd_miso;

	// Disk LED stretch, retriggered by every pulse
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			led_cnt <= '0;
		end else if (disk_activity) begin
			led_cnt <= LED_LOAD;
		end else if (led_cnt != '0) begin
			led_cnt <= led_cnt - 1'b1;
		end
	end

	assign led_user = (led_cnt != '0);

endmodule

//--- verilog/pcxt_splash_timer.sv
/*
 * Start-up splash timer, keeps the system in reset while the splash shows.
 * Ends after a fixed number of seconds or at once when the skip bit is set.
 */
`timescale 1ns/1ns

module pcxt_splash_timer #(
	parameter int SPLASH_SECOND_CYCLES = pcxt_timing_pkg::SPLASH_SECOND_DEFAULT
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic splash_skip,
	output logic splash_active
);
	import pcxt_timing_pkg::*;

	localparam int          SEC_W    = $clog2(SPLASH_SECONDS + 1);
	localparam hold_count_t CYC_LAST = hold_count_t'(SPLASH_SECOND_CYCLES - 1);
	localparam logic [SEC_W-1:0] SEC_LAST = SEC_W'(SPLASH_SECONDS - 1);

	hold_count_t      cyc_cnt;
	logic [SEC_W-1:0] sec_cnt;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cyc_cnt       <= '0;
			sec_cnt       <= '0;
			splash_active <= 1'b1;
		end else if (splash_active) begin
			if (splash_skip) begin
				// Skipped from the menu
				splash_active <= 1'b0;
			end else if (cyc_cnt == CYC_LAST) begin
				cyc_cnt <= '0;
				sec_cnt <= sec_cnt + 1'b1;
				// Last cycle of the last second
				if (sec_cnt == SEC_LAST) begin
					splash_active <= 1'b0;
				end
			end else begin
				cyc_cnt <= cyc_cnt + 1'b1;
			end
		end
	end

endmodule

//--- verilog/pcxt_clock_enables.sv
/*
 * Clock enables in the 50 MHz domain.
 * Exact 44.1 kHz audio strobe and a rising-edge enable from the FM-synth clock.
 */
`timescale 1ns/1ns

module pcxt_clock_enables (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic opl_clk,
	output logic cen_audio,
	output logic cen_opl
);
	import pcxt_timing_pkg::*;

	localparam audio_acc_t ACC_STEP = audio_acc_t'(AUDIO_RATE_HZ);
	localparam audio_acc_t ACC_WRAP = audio_acc_t'(SYS_CLK_HZ);

	audio_acc_t audio_acc;
	audio_acc_t audio_acc_next;
	logic [2:0] opl_sync;

	////////////////////
	// Audio strobe
	// Average rate is exactly AUDIO_RATE_HZ
	assign audio_acc_next = audio_acc + ACC_STEP;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			audio_acc <= '0;
			cen_audio <= 1'b0;
		end else if (audio_acc_next >= ACC_WRAP) begin
			// Overflow keeps the remainder
			audio_acc <= audio_acc_next - ACC_WRAP;
			cen_audio <= 1'b1;
		end else begin
			audio_acc <= audio_acc_next;
			cen_audio <= 1'b0;
		end
	end

	////////////////////
	// FM clock edge enable
	// Two flops to sync, third one for the edge
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			opl_sync <= '0;
			cen_opl  <= 1'b0;
		end else begin
			opl_sync <= {opl_sync[1:0], opl_clk};
			cen_opl  <= opl_sync[1] & ~opl_sync[2];
		end
	end

	// Strobe spacing is about 1134 cycles, never back to back
	a_audio_single: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		cen_audio |=> !cen_audio
	) else $error("cen_audio high on two cycles in a row");

endmodule

//--- verilog/pcxt_reset_seq.sv
/*
 * Reset sequencer of the system-control block.
 * Merges all reset sources, holds the system after they clear, then frees the CPU.
 */
`timescale 1ns/1ns

module pcxt_reset_seq #(
	parameter int POWERON_HOLD_CYCLES = pcxt_timing_pkg::POWERON_HOLD_DEFAULT
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic soft_reset,
	input  logic user_button,
	input  logic splash_active,
	output logic sys_reset,
	output logic cpu_reset
);
	import pcxt_cfg_pkg::*;
	import pcxt_timing_pkg::*;

	// Down-counter loads, a count of 0 releases on the next edge
	localparam hold_count_t POWERON_LOAD = hold_count_t'(POWERON_HOLD_CYCLES - 1);
	localparam hold_count_t CPU_LOAD     = hold_count_t'(CPU_RESET_DELAY - 1);

	reset_state_t state;
	hold_count_t  hold_cnt;
	logic         src_active;

	// Synchronous sources, reset_wire is handled asynchronously
	assign src_active = soft_reset | user_button | splash_active;

	////////////////////
	// Sequencer FSM
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state     <= HOLD_SOURCES;
			hold_cnt  <= '0;
			sys_reset <= 1'b1;
			cpu_reset <= 1'b1;
		end else if (src_active) begin
			// Any source restarts the whole sequence
			state     <= HOLD_SOURCES;
			hold_cnt  <= '0;
			sys_reset <= 1'b1;
			cpu_reset <= 1'b1;
		end else begin
			case (state)
				HOLD_SOURCES: begin
					// First quiet edge, start power-on hold
					state    <= POWERON_WAIT;
					hold_cnt <= POWERON_LOAD;
				end
				POWERON_WAIT: begin
					if (hold_cnt == '0) begin
						state     <= CPU_WAIT;
						sys_reset <= 1'b0;
						hold_cnt  <= CPU_LOAD;
					end else begin
						hold_cnt <= hold_cnt - 1'b1;
					end
				end
				CPU_WAIT: begin
					if (hold_cnt == '0) begin
						state     <= RUN;
						cpu_reset <= 1'b0;
					end else begin
						hold_cnt <= hold_cnt - 1'b1;
					end
				end
				// Stay here until a source shows up
				default: state <= RUN;
			endcase
		end
	end

	// CPU never runs while the chipset is still in reset
	a_cpu_in_reset: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> cpu_reset
	) else $error("cpu_reset low while sys_reset high");

endmodule

//--- verilog/pcxt_apb_regs.sv
/*
 * APB slave with zero wait states for the host configuration.
 * Holds the status word and image-mount flag, and reads back live reset state.
 */
`timescale 1ns/1ns

module pcxt_apb_regs (
	input  logic                    CLK_50M,
	input  logic                    reset_wire,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  pcxt_cfg_pkg::apb_addr_t paddr,
	input  pcxt_cfg_pkg::apb_data_t pwdata,
	output pcxt_cfg_pkg::apb_data_t prdata,
	input  logic                    sys_reset,
	input  logic                    cpu_reset,
	input  logic                    splash_active,
	output logic                    soft_reset,
	output logic                    mda_mode,
	output logic                    splash_skip,
	output logic                    vsd_mounted,
	output pcxt_cfg_pkg::aspect_sel_t aspect_sel
);
	import pcxt_cfg_pkg::*;

	status_word_t status_q;
	logic         wr_en;

	// Write lands on the edge ending the access phase
	assign wr_en = psel & penable & pwrite;

	////////////////////
	// Register writes
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			status_q    <= '0;
			vsd_mounted <= 1'b0;
		end else begin
			// Soft reset bit lives for one cycle only
			status_q[ST_SOFT_RESET] <= 1'b0;
			if (wr_en && paddr == REG_STATUS) begin
				status_q <= pwdata;
			end
			// Any nonzero write mounts the image
			if (wr_en && paddr == REG_IMAGE) begin
				vsd_mounted <= |pwdata;
			end
		end
	end

	// Config fields out of the status word
	assign soft_reset  = status_q[ST_SOFT_RESET];
	assign mda_mode    = status_q[ST_MDA_MODE];
	assign splash_skip = status_q[ST_SPLASH_SKIP];
	assign aspect_sel  = status_q[ST_ASPECT_LO +: 2];

	////////////////////
	// Read mux, valid in the access phase
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				REG_STATUS: prdata = status_q;
				REG_IMAGE:  prdata = apb_data_t'(vsd_mounted);
				// Live view of the reset chain
				REG_LIVE:   prdata = apb_data_t'({splash_active, cpu_reset, sys_reset});
				default:    prdata = '0;
			endcase
		end
	end

	// Host must hold psel through the whole transfer
	a_penable_needs_psel: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		penable |-> psel
	) else $error("APB penable high without psel");

endmodule

//--- verilog/pcxt_timing_pkg.sv
/*
 * Clock rates and timing defaults for the system-control block.
 * Hold lengths here are the defaults of the top-level parameters.
 */
package pcxt_timing_pkg;

	// System clock and audio sample rate
	localparam int SYS_CLK_HZ    = 50_000_000;
	localparam int AUDIO_RATE_HZ = 44_100;

	// Fractional accumulator for the audio strobe
	typedef logic [31:0] audio_acc_t;

	// General counter width for holds and delays
	typedef logic [31:0] hold_count_t;

	////////////////////
	// Reset timing

	// Power-on hold after the last reset source goes away
	localparam int POWERON_HOLD_DEFAULT = 65_535;
	// CPU reset release, after system reset release
	localparam int CPU_RESET_DELAY      = 42;

	// Splash screen, 5 seconds of 50M cycles
	localparam int SPLASH_SECONDS        = 5;
	localparam int SPLASH_SECOND_DEFAULT = 50_000_000;

	// Disk LED stretch, about 90 ms
	localparam int LED_HOLD_DEFAULT = 4_500_000;

endpackage

//--- verilog/pcxt_cfg_pkg.sv
/*
 * Host-visible configuration of the PC/XT system-control block.
 * Status word bit map, APB register map, board decode constants and FSM states.
 */
package pcxt_cfg_pkg;

	// APB bus widths
	typedef logic [3:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Host status word, bit map below
	typedef logic [31:0] status_word_t;

	localparam int ST_SOFT_RESET  = 0;
	localparam int ST_MDA_MODE    = 4;
	localparam int ST_SPLASH_SKIP = 7;
	// Aspect field is two bits wide, starting here
	localparam int ST_ASPECT_LO   = 8;

	// Video aspect ratio for the scaler
	typedef logic [1:0]  aspect_sel_t;
	typedef logic [12:0] video_ar_t;

	// Keyboard controller DIP switches
	typedef logic [7:0] dip_switch_t;
	typedef logic [3:0] dip_nibble_t;

	// CGA 80 column or MDA
	localparam dip_switch_t DIP_SW_CGA = 8'h2D;
	localparam dip_switch_t DIP_SW_MDA = 8'h3D;

	////////////////////
	// Register map
	localparam apb_addr_t REG_STATUS = 4'h0;
	localparam apb_addr_t REG_IMAGE  = 4'h4;
	localparam apb_addr_t REG_LIVE   = 4'h8;

	// Reset sequencer states
	typedef enum logic [1:0] {
		HOLD_SOURCES,
		POWERON_WAIT,
		CPU_WAIT,
		RUN
	} reset_state_t;

endpackage
